/* hmc_tester.f */
hmc_tester_pkg.sv
hmc_req_ctrl_if.sv
hmc_req_cfg.sv
hmc_req_gen.sv
hmc_rsp_check.sv
hmc_tester_top.sv
hmc_tester_checker.sv
hmc_tester_tb.sv

/* hmc_tester_tb.sv */
// LINK_ID 1, 16-cycle settling wait; 20 pairs under random stalls and gaps, three bad responses
`timescale 1ns/1ps

module hmc_tester_tb;

  localparam int LINK_ID     = 1;
  localparam int START_DELAY = 16;
  localparam int PAIRS       = 20;
  // Stalls and gaps at most quadruple the three cycles of a pair
  localparam int TIMEOUT     = PAIRS * 3 * 4 + START_DELAY + 200;
  localparam int INIT_AT     = 3;
  // Responses that get one flipped data bit in word 0, 1 and 2 respectively
  localparam int BAD_FIRST   = 4;
  localparam int BAD_MID     = 9;
  localparam int BAD_LAST    = 14;
  localparam int NUM_TESTS   = 7;

  logic         CLK;
  logic         RST;
  logic         init_done_i;
  logic         tx_valid_o;
  logic         tx_ready_i;
  logic [511:0] tx_data_o;
  logic [15:0]  tx_user_o;
  logic         rx_valid_i;
  logic         rx_ready_o;
  logic [511:0] rx_data_i;
  logic [15:0]  rx_user_i;
  logic [63:0]  rsp_cnt_o;
  logic [63:0]  err_cnt_o;
  logic         err_pulse_o;

  string test_name [NUM_TESTS] = '{"reset_values", "start_delay", "pair_headers",
                                   "write_data", "stall_order", "rsp_count", "err_inject"};
  int    test_err  [NUM_TESTS];

  logic [15:0]   lfsr_q;
  int            init_cycles;
  int            words_sent;
  int            stall_cycles;
  int            rsp_queued;
  int            rsp_returned;
  int            pulse_cnt;
  logic [511:0]  pair_word [3];
  logic [15:0]   pair_user [3];
  // Memory model keyed by the counted address
  logic [1023:0] mem [logic [27:0]];
  // Response words waiting for rx
  // Flag bit 0 marks LAST and bit 1 a corrupted response
  logic [511:0]  rsp_data [$];
  logic [15:0]   rsp_user [$];
  logic [1:0]    rsp_flag [$];
  // Accepted tx words for the compare process
  logic [511:0]  chk_word [$];
  logic [15:0]   chk_user [$];
  // Counter model lags two falling edges from LAST accepted to visible count
  logic [63:0]   exp_rsp;
  logic [63:0]   exp_err;
  logic          exp_pulse;
  logic          done_d1;
  logic          done_d2;
  logic          bad_d1;
  logic          bad_d2;

  hmc_tester_top #(
    .LINK_ID     (LINK_ID),
    .START_DELAY (START_DELAY)
  ) uut (
    .CLK         (CLK),
    .RST         (RST),
    .init_done_i (init_done_i),
    .tx_valid_o  (tx_valid_o),
    .tx_ready_i  (tx_ready_i),
    .tx_data_o   (tx_data_o),
    .tx_user_o   (tx_user_o),
    .rx_valid_i  (rx_valid_i),
    .rx_ready_o  (rx_ready_o),
    .rx_data_i   (rx_data_i),
    .rx_user_i   (rx_user_i),
    .rsp_cnt_o   (rsp_cnt_o),
    .err_cnt_o   (err_cnt_o),
    .err_pulse_o (err_pulse_o)
  );

  // Transmit assertions on the generator
  bind hmc_req_gen hmc_tester_checker u_checker (
    .CLK        (CLK),
    .RST        (RST),
    .tx_valid_i (tx_valid_o),
    .tx_ready_i (tx_ready_i),
    .tx_data_i  (tx_data_o),
    .tx_user_i  (tx_user_o)
  );

  initial begin : clock_gen
    CLK = 1'b0;
    forever begin
      #20 CLK = ~CLK;
    end
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  // 16-bit Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw_bits(input int n, output logic [7:0] v);
    int i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v      = {v[6:0], lfsr_q[0]};
    end
  endtask

  // Write data for a tag with the rotation advanced one place per 64-bit word
  function automatic logic [1023:0] ref_pattern(input logic [8:0] tag);
    logic [1023:0] p;
    logic [8:0]    r;
    int            k;
    p = '0;
    r = tag;
    for (k = 0; k < 16; k++) begin
      p[k*64 +: 64] = {k[3:0], r, ~r, r, ~r, r, ~r, 6'b000000};
      r = {r[7:0], r[8]};
    end
    return p;
  endfunction

  task automatic check_value(input int id, input string what,
                             input logic [1023:0] exp, input logic [1023:0] act);
    if (exp !== act) begin
      $display("** Error [%s] %s: expected %0h, actual %0h", test_name[id], what, exp, act);
      test_err[id]++;
    end
  endtask

  task automatic note_failure(input int id, input string msg);
    $display("[%s] %s", test_name[id], msg);
    test_err[id]++;
  endtask

  task automatic report_test(input int id);
    $display("test %-13s %s, %0d errors", test_name[id],
             (test_err[id] == 0) ? "ok" : "FAILED", test_err[id]);
  endtask

  // ----------------------------------------
  // Memory model
  // ----------------------------------------
  // Store the write, then queue the response to the read of the same pair
  task automatic record_pair();
    logic [1023:0] data;
    logic [1023:0] rd_data;
    logic [63:0]   wr_hdr;
    logic [63:0]   rd_hdr;
    logic [63:0]   rsp_hdr;
    logic [511:0]  w [3];
    logic          bad;
    int            i;
    data   = {pair_word[2][63:0], pair_word[1], pair_word[0][511:64]};
    wr_hdr = pair_word[0][63:0];
    rd_hdr = pair_word[2][191:128];
    // Counted address is header address bits 31:4
    mem[wr_hdr[55:28]] = data;
    for (i = 0; i < 3; i++) begin
      chk_word.push_back(pair_word[i]);
      chk_user.push_back(pair_user[i]);
    end
    if (mem.exists(rd_hdr[55:28])) begin
      rd_data = mem[rd_hdr[55:28]];
    end else begin
      note_failure(4, "read request for an address that was never written");
      rd_data = '0;
    end
    // Read response header with the request tag
    rsp_hdr        = '0;
    rsp_hdr[23:15] = rd_hdr[23:15];
    rsp_hdr[14:11] = 4'd9;
    rsp_hdr[10:7]  = 4'd9;
    rsp_hdr[5:0]   = 6'b111000;
    w[0] = {rd_data[447:0], rsp_hdr};
    w[1] = rd_data[959:448];
    w[2] = {384'd0, 64'd0, rd_data[1023:960]};
    bad  = (rsp_queued == BAD_FIRST) || (rsp_queued == BAD_MID) || (rsp_queued == BAD_LAST);
    if (rsp_queued == BAD_FIRST) w[0][200] = ~w[0][200];
    if (rsp_queued == BAD_MID)   w[1][333] = ~w[1][333];
    if (rsp_queued == BAD_LAST)  w[2][17]  = ~w[2][17];
    rsp_data.push_back(w[0]);
    rsp_user.push_back(16'h001F);
    rsp_flag.push_back(2'b00);
    rsp_data.push_back(w[1]);
    rsp_user.push_back(16'h000F);
    rsp_flag.push_back(2'b00);
    rsp_data.push_back(w[2]);
    rsp_user.push_back(16'h0101);
    rsp_flag.push_back({bad, 1'b1});
    rsp_queued++;
  endtask

  // ----------------------------------------
  // Drive inputs on one falling edge and note transfers at the next rising edge
  // ----------------------------------------
  task automatic step_cycle();
    logic [7:0] r;
    logic [1:0] flag;
    // Qualified settling cycles up to and including the next rising edge
    if (init_done_i) init_cycles++;
    if (tx_valid_o && init_cycles <= START_DELAY + 1) begin
      note_failure(1, "tx_valid_o rose before the settling wait was over");
    end
    if (init_cycles == START_DELAY + 2) begin
      check_value(1, "tx_valid_o after settling wait", 1'b1, tx_valid_o);
    end
    // Random stalls until all pairs are taken, then hold off for good
    if (words_sent < PAIRS * 3) begin
      draw_bits(2, r);
      tx_ready_i = (r[1:0] != 2'b00);
      if (tx_valid_o && !tx_ready_i) stall_cycles++;
    end else begin
      tx_ready_i = 1'b0;
    end
    if (tx_valid_o && tx_ready_i) begin
      pair_word[words_sent % 3] = tx_data_o;
      pair_user[words_sent % 3] = tx_user_o;
      words_sent++;
      if (words_sent % 3 == 0) record_pair();
    end
    // Response words with random gaps
    rx_valid_i = 1'b0;
    if (rsp_data.size() > 0) begin
      draw_bits(2, r);
      if (r[1:0] != 2'b00) begin
        rx_valid_i = 1'b1;
        rx_data_i  = rsp_data[0];
        rx_user_i  = rsp_user[0];
      end
    end
    // Counters and pulse
    if (done_d2) begin
      exp_rsp++;
      if (bad_d2) exp_err++;
    end
    exp_pulse = done_d2 && bad_d2;
    check_value(5, "rsp_cnt_o", exp_rsp, rsp_cnt_o);
    check_value(6, "err_cnt_o", exp_err, err_cnt_o);
    check_value(6, "err_pulse_o", exp_pulse, err_pulse_o);
    if (err_pulse_o) pulse_cnt++;
    done_d2 = done_d1;
    bad_d2  = bad_d1;
    done_d1 = 1'b0;
    bad_d1  = 1'b0;
    if (rx_valid_i && rx_ready_o) begin
      flag = rsp_flag.pop_front();
      void'(rsp_data.pop_front());
      void'(rsp_user.pop_front());
      if (flag[0]) begin
        done_d1 = 1'b1;
        bad_d1  = flag[1];
        rsp_returned++;
      end
    end
  endtask

  // ----------------------------------------
  // Compare process for transmitted pairs
  // ----------------------------------------
  initial begin : compare_pairs
    logic [511:0] w0;
    logic [511:0] w1;
    logic [511:0] w2;
    logic [15:0]  u0;
    logic [15:0]  u1;
    logic [15:0]  u2;
    logic [63:0]  exp_wr;
    logic [63:0]  exp_rd;
    logic [8:0]   exp_tag;
    logic [27:0]  exp_addr;
    exp_tag  = 9'd1;
    exp_addr = (LINK_ID == 1) ? 28'd8 : 28'd0;
    forever begin
      @(posedge CLK);
      while (chk_word.size() >= 3) begin
        w0 = chk_word.pop_front();
        w1 = chk_word.pop_front();
        w2 = chk_word.pop_front();
        u0 = chk_user.pop_front();
        u1 = chk_user.pop_front();
        u2 = chk_user.pop_front();
        check_value(2, "FIRST user", 16'h001F, u0);
        check_value(2, "MID user", 16'h000F, u1);
        check_value(2, "LAST user", 16'h0323, u2);
        // Zero cube id and reserved bits around an address padded by 2 zero bits above and 4 below
        exp_wr = {6'd0, 2'b00, exp_addr, 4'd0, exp_tag, 4'd9, 4'd9, 1'b0, 6'b011111};
        exp_rd = {6'd0, 2'b00, exp_addr, 4'd0, exp_tag, 4'd1, 4'd1, 1'b0, 6'b110111};
        check_value(2, "write header", exp_wr, w0[63:0]);
        check_value(2, "read header", exp_rd, w2[191:128]);
        check_value(2, "zero fields of LAST", 0, {w2[511:192], w2[127:64]});
        check_value(3, "write data", ref_pattern(exp_tag), {w2[63:0], w1, w0[511:64]});
        check_value(4, "tag order", exp_tag, w0[23:15]);
        exp_tag  = exp_tag + 9'd1;
        exp_addr = exp_addr + 28'd16;
      end
    end
  end

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin : main_flow
    logic timed_out;
    int   cycles;
    int   drain;
    int   total_err;
    int   failed_tests;
    int   i;
    RST          = 1'b1;
    init_done_i  = 1'b0;
    tx_ready_i   = 1'b0;
    rx_valid_i   = 1'b0;
    rx_data_i    = '0;
    rx_user_i    = '0;
    lfsr_q       = 16'd97;
    init_cycles  = 0;
    words_sent   = 0;
    stall_cycles = 0;
    rsp_queued   = 0;
    rsp_returned = 0;
    pulse_cnt    = 0;
    exp_rsp      = '0;
    exp_err      = '0;
    exp_pulse    = 1'b0;
    done_d1      = 1'b0;
    done_d2      = 1'b0;
    bad_d1       = 1'b0;
    bad_d2       = 1'b0;
    timed_out    = 1'b0;
    cycles       = 0;
    drain        = 0;
    total_err    = 0;
    failed_tests = 0;
    for (i = 0; i < NUM_TESTS; i++) test_err[i] = 0;
    // Two rising edges in reset
    @(posedge CLK);
    @(posedge CLK);
    @(negedge CLK);
    check_value(0, "tx_valid_o in reset", 1'b0, tx_valid_o);
    check_value(0, "rx_ready_o in reset", 1'b0, rx_ready_o);
    check_value(0, "err_pulse_o in reset", 1'b0, err_pulse_o);
    check_value(0, "rsp_cnt_o in reset", 0, rsp_cnt_o);
    check_value(0, "err_cnt_o in reset", 0, err_cnt_o);
    RST = 1'b0;
    @(negedge CLK);
    check_value(0, "rx_ready_o after reset", 1'b1, rx_ready_o);
    report_test(0);
    step_cycle();
    // Run until all responses are back and the counters have settled
    while (drain < 4 && !timed_out) begin
      @(negedge CLK);
      cycles++;
      if (cycles == INIT_AT) init_done_i = 1'b1;
      step_cycle();
      if (rsp_returned == PAIRS && rsp_data.size() == 0) drain++;
      if (cycles >= TIMEOUT) timed_out = 1'b1;
    end
    if (timed_out) begin
      note_failure(5, $sformatf("timeout after %0d cycles with %0d of %0d responses back",
                                cycles, rsp_returned, PAIRS));
    end
    if (stall_cycles == 0) note_failure(4, "tx_ready_i never stalled a pending word");
    if (uut.u_req_gen.u_checker.fail_cnt != 0) begin
      note_failure(4, "transmit assertions fired during the run");
    end
    check_value(5, "final rsp_cnt_o", PAIRS, rsp_cnt_o);
    check_value(6, "final err_cnt_o", 3, err_cnt_o);
    check_value(6, "err_pulse_o count", 3, pulse_cnt);
    for (i = 1; i < NUM_TESTS; i++) report_test(i);
    for (i = 0; i < NUM_TESTS; i++) begin
      total_err += test_err[i];
      if (test_err[i] != 0) failed_tests++;
    end
    $display("Tests: %0d passed, %0d failed, %0d errors", NUM_TESTS - failed_tests,
             failed_tests, total_err);
    if (total_err == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* hmc_tester_checker.sv */
// Bound into hmc_req_gen; samples on rising CLK, expects synchronous active-high RST
`timescale 1ns/1ps

module hmc_tester_checker (
  input logic         CLK,
  input logic         RST,
  input logic         tx_valid_i,
  input logic         tx_ready_i,
  input logic [511:0] tx_data_i,
  input logic [15:0]  tx_user_i
);

  // Number of assertion failures so far
  int fail_cnt = 0;

  // ----------------------------------------
  // Transmit handshake
  // ----------------------------------------
  // A stalled word stays valid and unchanged
  a_hold_stalled: assert property (@(posedge CLK) disable iff (RST)
    (tx_valid_i && !tx_ready_i) |=> (tx_valid_i && $stable(tx_data_i) && $stable(tx_user_i)))
    else begin
      $error("tx word changed or dropped while stalled");
      fail_cnt++;
    end

  // Nothing offered while in reset
  a_reset_idle: assert property (@(posedge CLK) RST |=> !tx_valid_i)
    else begin
      $error("tx_valid_o high after a reset cycle");
      fail_cnt++;
    end

endmodule

/* hmc_tester_top.sv */
// One HMC link only; tx stream must accept words in order, rx responses must carry header in FLIT0
`timescale 1ns/1ps

module hmc_tester_top #(
  parameter int LINK_ID     = 0,
  parameter int START_DELAY = 256
) (
  input  logic                              CLK,
  input  logic                              RST,
  input  logic                              init_done_i,
  // Transmit stream towards the controller
  output logic                              tx_valid_o,
  input  logic                              tx_ready_i,
  output logic [hmc_tester_pkg::WORD_W-1:0] tx_data_o,
  output logic [hmc_tester_pkg::USER_W-1:0] tx_user_o,
  // Receive stream from the controller
  input  logic                              rx_valid_i,
  output logic                              rx_ready_o,
  input  logic [hmc_tester_pkg::WORD_W-1:0] rx_data_i,
  input  logic [hmc_tester_pkg::USER_W-1:0] rx_user_i,
  // Status
  output logic [63:0]                       rsp_cnt_o,
  output logic [63:0]                       err_cnt_o,
  output logic                              err_pulse_o
);

  // Start, tag, address and advance between counters and generator
  hmc_req_ctrl_if req_ctrl ();

  // ----------------------------------------
  // Request side
  // ----------------------------------------
  hmc_req_cfg #(
    .LINK_ID     (LINK_ID),
    .START_DELAY (START_DELAY)
  ) u_req_cfg (
    .CLK         (CLK),
    .RST         (RST),
    .init_done_i (init_done_i),
    .ctrl        (req_ctrl.cfg)
  );

  hmc_req_gen u_req_gen (
    .CLK        (CLK),
    .RST        (RST),
    .ctrl       (req_ctrl.gen),
    .tx_valid_o (tx_valid_o),
    .tx_ready_i (tx_ready_i),
    .tx_data_o  (tx_data_o),
    .tx_user_o  (tx_user_o)
  );

  // ----------------------------------------
  // Response side
  // ----------------------------------------
  // Runs from reset release, independent of init_done_i
  hmc_rsp_check u_rsp_check (
    .CLK         (CLK),
    .RST         (RST),
    .rx_valid_i  (rx_valid_i),
    .rx_ready_o  (rx_ready_o),
    .rx_data_i   (rx_data_i),
    .rx_user_i   (rx_user_i),
    .rsp_cnt_o   (rsp_cnt_o),
    .err_cnt_o   (err_cnt_o),
    .err_pulse_o (err_pulse_o)
  );

endmodule

/* hmc_rsp_check.sv */
// Checks only read responses with the header in FLIT0; counters wrap at 2**64
`timescale 1ns/1ps

module hmc_rsp_check (
  input  logic                              CLK,
  input  logic                              RST,
  input  logic                              rx_valid_i,
  output logic                              rx_ready_o,
  input  logic [hmc_tester_pkg::WORD_W-1:0] rx_data_i,
  input  logic [hmc_tester_pkg::USER_W-1:0] rx_user_i,
  output logic [63:0]                       rsp_cnt_o,
  output logic [63:0]                       err_cnt_o,
  output logic                              err_pulse_o
);

  // Tracking phase of the open response
  localparam logic [1:0] P_IDLE = 2'd0;
  localparam logic [1:0] P_MID  = 2'd1;
  localparam logic [1:0] P_LAST = 2'd2;

  logic                                 accept;
  logic                                 is_first;
  logic                                 is_mid;
  logic                                 is_last;
  hmc_tester_pkg::flit_t                rx_flit0;
  logic [hmc_tester_pkg::TAG_W-1:0]     rx_tag;
  logic [hmc_tester_pkg::TAG_W-1:0]     chk_tag;
  logic [hmc_tester_pkg::TAG_W-1:0]     tag_q;
  logic [hmc_tester_pkg::PATTERN_W-1:0] exp_pat;
  logic                                 mis_first;
  logic                                 mis_mid;
  logic                                 mis_last;
  logic [1:0]                           phase_q;
  logic                                 err_q;
  logic                                 done_q;
  logic                                 done_err_q;

  assign accept = rx_valid_i && rx_ready_o;

  // Word kind from the flag pattern
  assign is_first = (rx_user_i[11:0] == hmc_tester_pkg::USER_RSP_FIRST);
  assign is_mid   = (rx_user_i[11:0] == hmc_tester_pkg::USER_RSP_MID);
  assign is_last  = (rx_user_i[11:0] == hmc_tester_pkg::USER_RSP_LAST);

  // ----------------------------------------
  // Expected data and compare
  // ----------------------------------------
  always_comb begin
    rx_flit0.raw = rx_data_i[hmc_tester_pkg::FLIT_W-1:0];
    rx_tag       = rx_flit0.ctrl.hdr.tag;
    // FIRST brings its own tag, later words use the captured one
    chk_tag      = is_first ? rx_tag : tag_q;
    exp_pat      = hmc_tester_pkg::test_pattern(chk_tag);
    // Upper half of FLIT0 is data, not a tail, in a FIRST word
    mis_first    = {rx_data_i[hmc_tester_pkg::WORD_W-1:hmc_tester_pkg::FLIT_W],
                    rx_flit0.ctrl.tail} != exp_pat[447:0];
    mis_mid      = rx_data_i != exp_pat[959:448];
    // Tail above bit 63 is not compared
    mis_last     = rx_data_i[63:0] != exp_pat[1023:960];
  end

  // ----------------------------------------
  // Response tracking
  // ----------------------------------------
  always_ff @(posedge CLK) begin
    if (RST) begin
      rx_ready_o <= 1'b0;
      phase_q    <= P_IDLE;
      err_q      <= 1'b0;
      done_q     <= 1'b0;
    end else begin
      // Always ready from the first cycle out of reset
      rx_ready_o <= 1'b1;
      done_q     <= 1'b0;
      if (accept && is_first) begin
        // Also restarts an open response, which is then dropped
        phase_q <= P_MID;
        err_q   <= mis_first;
      end else if (accept && is_mid && phase_q == P_MID) begin
        phase_q <= P_LAST;
        err_q   <= err_q | mis_mid;
      end else if (accept && is_last && phase_q == P_LAST) begin
        phase_q <= P_IDLE;
        done_q  <= 1'b1;
      end
      // Stray MID or LAST words fall through untouched
    end
  end

  // Captured tag and final mismatch, qualified by phase_q and done_q
  always_ff @(posedge CLK) begin
    if (accept && is_first) begin
      tag_q <= rx_tag;
    end
    done_err_q <= err_q | mis_last;
  end

  // ----------------------------------------
  // Counters, one cycle after the last word
  // ----------------------------------------
  always_ff @(posedge CLK) begin
    if (RST) begin
      rsp_cnt_o   <= '0;
      err_cnt_o   <= '0;
      err_pulse_o <= 1'b0;
    end else begin
      err_pulse_o <= done_q && done_err_q;
      if (done_q) begin
        rsp_cnt_o <= rsp_cnt_o + 64'd1;
        if (done_err_q) begin
          err_cnt_o <= err_cnt_o + 64'd1;
        end
      end
    end
  end

endmodule

/* hmc_req_gen.sv */
// Emits FIRST/MID/LAST words back to back once start is high; holds a word until tx_ready_i
`timescale 1ns/1ps

module hmc_req_gen (
  input  logic                                CLK,
  input  logic                                RST,
  hmc_req_ctrl_if.gen                         ctrl,
  output logic                                tx_valid_o,
  input  logic                                tx_ready_i,
  output logic [hmc_tester_pkg::WORD_W-1:0]   tx_data_o,
  output logic [hmc_tester_pkg::USER_W-1:0]   tx_user_o
);

  // Word position within a request pair
  localparam logic [1:0] S_FIRST = 2'd0;
  localparam logic [1:0] S_MID   = 2'd1;
  localparam logic [1:0] S_LAST  = 2'd2;

  localparam int USER_PAD = hmc_tester_pkg::USER_W - 12;

  logic [1:0]                             state_q;
  logic [1:0]                             state_d;
  logic                                   load;
  logic [hmc_tester_pkg::PATTERN_W-1:0]   pattern;
  hmc_tester_pkg::hdr_t                   wr_hdr;
  hmc_tester_pkg::hdr_t                   rd_hdr;
  hmc_tester_pkg::flit_t                  wr_flit0;
  hmc_tester_pkg::flit_t                  rd_flit1;
  logic [hmc_tester_pkg::WORD_W-1:0]      word_d;
  logic [11:0]                            user_d;

  // Output register is free, or its word leaves this edge
  assign load = ctrl.start && (!tx_valid_o || tx_ready_i);

  // Counters step as the last word is loaded, so the next FIRST sees the new tag
  assign ctrl.advance = load && (state_q == S_LAST);

  assign pattern = hmc_tester_pkg::test_pattern(ctrl.tag);

  // ----------------------------------------
  // Headers
  // ----------------------------------------
  always_comb begin
    // Cube id and reserved fields stay zero
    wr_hdr      = '0;
    wr_hdr.addr = {2'b00, ctrl.addr, 4'b0000};
    wr_hdr.tag  = ctrl.tag;
    wr_hdr.dln  = hmc_tester_pkg::LNG_WR128;
    wr_hdr.lng  = hmc_tester_pkg::LNG_WR128;
    wr_hdr.cmd  = hmc_tester_pkg::CMD_P_WR128;
    // Read of the same block with the same tag
    rd_hdr      = wr_hdr;
    rd_hdr.dln  = hmc_tester_pkg::LNG_RD128;
    rd_hdr.lng  = hmc_tester_pkg::LNG_RD128;
    rd_hdr.cmd  = hmc_tester_pkg::CMD_RD128;
  end

  // FLIT0 of the write carries the first data beat above the header
  // FLIT1 of the last word holds a zero tail above the read header
  always_comb begin
    wr_flit0.raw      = {pattern[63:0], 64'd0};
    wr_flit0.ctrl.hdr = wr_hdr;
    rd_flit1.raw      = '0;
    rd_flit1.ctrl.hdr = rd_hdr;
  end

  // ----------------------------------------
  // Next word
  // ----------------------------------------
  always_comb begin
    case (state_q)
      S_MID: begin
        word_d  = pattern[959:448];
        user_d  = hmc_tester_pkg::USER_WR_MID;
        state_d = S_LAST;
      end
      S_LAST: begin
        // FLIT3/2 null, FLIT1 read request, FLIT0 last data and write tail
        word_d  = {256'd0, rd_flit1.raw, 64'd0, pattern[1023:960]};
        user_d  = hmc_tester_pkg::USER_WR_LAST;
        state_d = S_FIRST;
      end
      default: begin
        word_d  = {pattern[447:64], wr_flit0.raw};
        user_d  = hmc_tester_pkg::USER_WR_FIRST;
        state_d = S_MID;
      end
    endcase
  end

  // Valid and sequence position step only on load
  always_ff @(posedge CLK) begin
    if (RST) begin
      state_q    <= S_FIRST;
      tx_valid_o <= 1'b0;
    end else if (load) begin
      state_q    <= state_d;
      tx_valid_o <= 1'b1;
    end
  end

  // Payload changes only on load, so it holds while stalled
  always_ff @(posedge CLK) begin
    if (load) begin
      tx_data_o <= word_d;
      tx_user_o <= {{USER_PAD{1'b0}}, user_d};
    end
  end

endmodule

/* hmc_req_cfg.sv */
// START_DELAY must be at least 1; LINK_ID 1 gives odd 8-byte parity, tag wraps after 511
`timescale 1ns/1ps

module hmc_req_cfg #(
  parameter int LINK_ID     = 0,
  parameter int START_DELAY = 256
) (
  input  logic        CLK,
  input  logic        RST,
  input  logic        init_done_i,
  hmc_req_ctrl_if.cfg ctrl
);

  // Counter wide enough to hold START_DELAY
  localparam int CNT_W = $clog2(START_DELAY + 1);
  localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(START_DELAY - 1);

  // Bit 3 selects the link, stepping by 16 never touches it
  localparam logic [hmc_tester_pkg::ADDR_W-1:0] ADDR_INIT =
    (LINK_ID == 1) ? hmc_tester_pkg::ADDR_W'(8) : '0;
  localparam logic [hmc_tester_pkg::ADDR_W-1:0] ADDR_STEP = hmc_tester_pkg::ADDR_W'(16);

  logic [CNT_W-1:0] settle_cnt_q;

  // ----------------------------------------
  // Settling wait
  // ----------------------------------------
  // Only cycles with init_done_i high count
  always_ff @(posedge CLK) begin
    if (RST) begin
      settle_cnt_q <= '0;
      ctrl.start   <= 1'b0;
    end else if (init_done_i && !ctrl.start) begin
      settle_cnt_q <= settle_cnt_q + 1'b1;
      // START_DELAY-th qualified cycle
      if (settle_cnt_q == LAST_CNT) begin
        ctrl.start <= 1'b1;
      end
    end
  end

  // ----------------------------------------
  // Tag and address stepping
  // ----------------------------------------
  always_ff @(posedge CLK) begin
    if (RST) begin
      ctrl.tag  <= hmc_tester_pkg::TAG_W'(1);
      ctrl.addr <= ADDR_INIT;
    end else if (ctrl.advance) begin
      // Natural wrap of the 9-bit tag
      ctrl.tag  <= ctrl.tag + 1'b1;
      // One 128-byte block per pair
      ctrl.addr <= ctrl.addr + ADDR_STEP;
    end
  end

endmodule

/* hmc_req_ctrl_if.sv */
// Request control between settling/counter block and generator; no clock, signals only
`timescale 1ns/1ps

interface hmc_req_ctrl_if;

  // Level, high for good once the settling wait is over
  logic                             start;
  // Tag of the pair being built
  logic [hmc_tester_pkg::TAG_W-1:0]  tag;
  // Counted address, 16-byte granularity
  logic [hmc_tester_pkg::ADDR_W-1:0] addr;
  // One-cycle pulse, last word of a pair taken by the generator
  logic                             advance;

  // Counter side
  modport cfg (
    output start,
    output tag,
    output addr,
    input  advance
  );

  // Generator side
  modport gen (
    input  start,
    input  tag,
    input  addr,
    output advance
  );

endinterface

/* hmc_tester_pkg.sv */
// Fixed 4-FLIT (512-bit) word layout; describes only P_WR128/RD128 pairs and FLIT0-aligned responses
package hmc_tester_pkg;

  // ----------------------------------------
  // Widths
  // ----------------------------------------
  localparam int FLIT_W         = 128;
  localparam int FLITS_PER_WORD = 4;
  localparam int WORD_W         = FLIT_W * FLITS_PER_WORD;
  // Only bits 11:0 carry flags (valid 3:0, header 7:4, tail 11:8)
  localparam int USER_W         = 16;
  localparam int TAG_W          = 9;
  // Counted address in 16-byte units, header adds 2 zero bits above and 4 below
  localparam int ADDR_W         = 28;
  localparam int PATTERN_W      = 1024;

  // Request commands and lengths in FLITs
  localparam logic [5:0] CMD_P_WR128 = 6'b011111;
  localparam logic [5:0] CMD_RD128   = 6'b110111;
  localparam logic [3:0] LNG_WR128   = 4'd9;
  localparam logic [3:0] LNG_RD128   = 4'd1;

  // ----------------------------------------
  // TUSER flag patterns
  // ----------------------------------------
  // Write header and data, all four FLITs valid
  localparam logic [11:0] USER_WR_FIRST  = 12'b0000_0001_1111;
  localparam logic [11:0] USER_WR_MID    = 12'b0000_0000_1111;
  // Write tail in FLIT0, read header+tail in FLIT1, FLIT2/3 null
  localparam logic [11:0] USER_WR_LAST   = 12'b0011_0010_0011;
  localparam logic [11:0] USER_RSP_FIRST = 12'b0000_0001_1111;
  localparam logic [11:0] USER_RSP_MID   = 12'b0000_0000_1111;
  // Only FLIT0 valid, carrying data and the tail
  localparam logic [11:0] USER_RSP_LAST  = 12'b0001_0000_0001;

  // Request/response header, 64 bits
  typedef struct packed {
    logic [2:0]  cub;
    logic [2:0]  res_hi;
    logic [33:0] addr;
    logic [8:0]  tag;
    logic [3:0]  dln;
    logic [3:0]  lng;
    logic        res_lo;
    logic [5:0]  cmd;
  } hdr_t;

  // One FLIT seen as raw bits or as tail over header
  typedef union packed {
    logic [FLIT_W-1:0] raw;
    struct packed {
      logic [63:0] tail;
      hdr_t        hdr;
    } ctrl;
  } flit_t;

  // ----------------------------------------
  // Write data pattern for one tag
  // ----------------------------------------
  // Sixteen 64-bit words, word k holds k, then rotated tag r alternating with ~r
  function automatic logic [PATTERN_W-1:0] test_pattern(input logic [TAG_W-1:0] tag);
    logic [PATTERN_W-1:0] pat;
    logic [TAG_W-1:0]     r;
    int                   k;
    int                   sh;
    pat = '0;
    for (k = 0; k < 16; k++) begin
      sh = k % TAG_W;
      // Rotate left, shift by TAG_W gives zero so sh of 0 is safe
      r  = (tag << sh) | (tag >> (TAG_W - sh));
      pat[k*64 +: 64] = {4'(k), r, ~r, r, ~r, r, ~r, 6'd0};
    end
    return pat;
  endfunction

endpackage
